// File: Makefile
# verilator build, run and lint for the wishbone subsystem
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= wb_subsystem_tb
RTL_TOP   ?= wb_subsystem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
source/wb_pkg.sv
source/wb_interconnect.sv
source/wb_ram_slave.sv
source/wb_gpio_slave.sv
source/wb_subsystem.sv
tests/wb_subsystem_tb.sv

// File: source/wb_gpio_slave.sv
// gpio slave with a writable output register and a synchronised input register
// never stalls and acks one cycle after the request

`default_nettype none

module wb_gpio_slave
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  wb_pkg::wb_addr_t addr,
    input  wb_pkg::wb_sel_t  sel,
    input  wb_pkg::wb_data_t wdata,
    input  wb_pkg::gpio_t    gpio_in,
    output wb_pkg::wb_data_t rdata,
    output logic             ack,
    output logic             stall,
    output wb_pkg::gpio_t    gpio_out
);

    import wb_pkg::*;

    logic     accept;
    wb_addr_t ofs;
    gpio_t    in_meta;
    gpio_t    in_sync;

    assign stall  = 1'b0;
    assign accept = cyc & stb;

    // register offset within the gpio window
    assign ofs = addr & ~GPIO_MASK;

    // two-flop synchroniser on the input port
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // writes to the input register are acked and dropped
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            ack      <= 1'b0;
            gpio_out <= '0;
        end
        else
        begin
            ack <= accept;
            if (accept && we && sel[0] && ofs == wb_addr_t'(GPIO_OUT_OFS))
                gpio_out <= wdata[$bits(gpio_t)-1:0];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (accept && !we)
        begin
            case (ofs)
                wb_addr_t'(GPIO_OUT_OFS): rdata <= wb_data_t'(gpio_out);
                wb_addr_t'(GPIO_IN_OFS):  rdata <= wb_data_t'(in_sync);
                default:                  rdata <= '0;
            endcase
        end
    end

endmodule : wb_gpio_slave

`default_nettype wire

// File: source/wb_interconnect.sv
// single master wishbone interconnect for NUM_SLAVES pipelined slaves
// decodes the master address, routes stb to one slave and registers the response
// the master must wait for ack or err before it issues the next request

`default_nettype none

module wb_interconnect
#(
    parameter int               NUM_SLAVES = 2,
    parameter wb_pkg::wb_addr_t START_ADDRESS [NUM_SLAVES] = '{default: '0},
    parameter wb_pkg::wb_addr_t MASK [NUM_SLAVES] = '{default: '0}
)
(
    input  logic                                clk_i,
    input  logic                                rstn_i,

    // master side
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  wb_pkg::wb_addr_t                    addr,
    input  wb_pkg::wb_sel_t                     sel,
    input  wb_pkg::wb_data_t                    wdata,
    output wb_pkg::wb_data_t                    rdata,
    output logic                                ack,
    output logic                                err,
    output logic                                stall,

    // slave side, one bit or one word per slave
    output logic [NUM_SLAVES-1:0]               s_cyc,
    output logic [NUM_SLAVES-1:0]               s_stb,
    output logic                                s_we,
    output wb_pkg::wb_addr_t                    s_addr,
    output wb_pkg::wb_sel_t                     s_sel,
    output wb_pkg::wb_data_t                    s_wdata,
    input  logic [NUM_SLAVES-1:0]               s_ack,
    input  logic [NUM_SLAVES-1:0]               s_stall,
    input  wb_pkg::wb_data_t [NUM_SLAVES-1:0]   s_rdata
);

    import wb_pkg::*;

    logic                  req;
    logic [NUM_SLAVES-1:0] hit;
    logic [NUM_SLAVES-1:0] grant;

    wb_data_t rdata_d;
    wb_data_t rdata_q;
    logic     ack_d;
    logic     ack_q;

    assign req = cyc & stb;

    // window match on the master address
    for (genvar i = 0; i < NUM_SLAVES; i++)
    begin : g_decode
        assign hit[i] = ((addr & MASK[i]) == START_ADDRESS[i]);
    end

    // scan downwards so the lowest matching index is the one left standing
    always_comb
    begin
        grant = '0;
        for (int i = NUM_SLAVES - 1; i >= 0; i--)
        begin
            if (hit[i])
            begin
                grant    = '0;
                grant[i] = 1'b1;
            end
        end
    end

    // request fan-out, only the granted slave gets stb
    assign s_cyc   = {NUM_SLAVES{cyc}};
    assign s_stb   = {NUM_SLAVES{req}} & grant;
    assign s_we    = we;
    assign s_addr  = addr;
    assign s_sel   = sel;
    assign s_wdata = wdata;

    // read data of whichever slave acks
    always_comb
    begin
        rdata_d = '0;
        for (int i = 0; i < NUM_SLAVES; i++)
        begin
            if (s_ack[i])
            begin
                rdata_d = s_rdata[i];
            end
        end
    end

    assign ack_d = |s_ack;

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end
        else
        begin
            ack_q   <= ack_d;
            rdata_q <= rdata_d;
        end
    end

    assign ack   = ack_q;
    assign rdata = rdata_q;
    assign stall = |s_stall;

    // unmapped request ends here without any slave seeing it
    assign err = req & ~(|hit);

    // only one outstanding request, so only one slave can answer
    a_single_ack : assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(s_ack))
        else $error("more than one slave acked in the same cycle");

    // an unmapped request is ended by err alone, with no slave strobed or answering
    a_err_no_stb : assert property (@(posedge clk_i) disable iff (!rstn_i)
        err |-> ((s_stb == '0) && (s_ack == '0)))
        else $error("err raised while a slave strobe or ack is active");

endmodule : wb_interconnect

`default_nettype wire

// File: source/wb_pkg.sv
// wishbone subsystem definitions
// bus field widths, gpio port width and the address map of both slaves

`default_nettype none

package wb_pkg;

    // bus fields
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // gpio port value
    typedef logic [7:0] gpio_t;

    // word ram with a 1 KiB window holding 256 words
    localparam wb_addr_t RAM_BASE = 32'h0000_0000;
    localparam wb_addr_t RAM_MASK = 32'hFFFF_FC00;

    // gpio block with a 16 byte window
    localparam wb_addr_t GPIO_BASE = 32'h0001_0000;
    localparam wb_addr_t GPIO_MASK = 32'hFFFF_FFF0;

    // register offsets inside the gpio window
    localparam int GPIO_OUT_OFS = 'h0;
    localparam int GPIO_IN_OFS  = 'h4;

endpackage : wb_pkg

`default_nettype wire

// File: source/wb_ram_slave.sv
// word ram slave for a pipelined wishbone bus
// stalls each request for RAM_WAIT_STATES cycles and acks one cycle after accept

`default_nettype none

module wb_ram_slave
#(
    parameter int RAM_DEPTH       = 256,
    parameter int RAM_WAIT_STATES = 2
)
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  wb_pkg::wb_addr_t addr,
    input  wb_pkg::wb_sel_t  sel,
    input  wb_pkg::wb_data_t wdata,
    output wb_pkg::wb_data_t rdata,
    output logic             ack,
    output logic             stall
);

    import wb_pkg::*;

    localparam int IDX_W = $clog2(RAM_DEPTH);
    localparam int CNT_W = (RAM_WAIT_STATES > 0) ? $clog2(RAM_WAIT_STATES + 1) : 1;

    wb_data_t mem [RAM_DEPTH];

    logic             req;
    logic             accept;
    logic [CNT_W-1:0] wait_cnt;
    logic [IDX_W-1:0] word_idx;

    // word index wraps by slicing, which needs a power-of-two depth
    if ((RAM_DEPTH & (RAM_DEPTH - 1)) != 0)
    begin : g_depth_check
        $error("RAM_DEPTH must be a power of two");
    end

    assign req      = cyc & stb;
    assign stall    = req & (wait_cnt != CNT_W'(RAM_WAIT_STATES));
    assign accept   = req & ~stall;
    assign word_idx = addr[IDX_W+1:2];

    // counts stalled cycles of the pending request
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            wait_cnt <= '0;
        end
        else if (stall)
        begin
            wait_cnt <= wait_cnt + 1'b1;
        end
        else
        begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
            ack <= 1'b0;
        else
            ack <= accept;
    end

    // byte-lane writes and word reads on the accepting edge
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            if (we)
            begin
                for (int b = 0; b < $bits(wb_sel_t); b++)
                begin
                    if (sel[b])
                        mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            else
            begin
                rdata <= mem[word_idx];
            end
        end
    end

    // a master that keeps stb up past acceptance would trip this
    a_ack_single : assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack |=> !ack)
        else $error("ram slave acked two cycles in a row");

endmodule : wb_ram_slave

`default_nettype wire

// File: source/wb_subsystem.sv
// wishbone subsystem with one master port, a word ram and a gpio block
// slave 0 is the ram and slave 1 is the gpio block

`default_nettype none

module wb_subsystem
#(
    parameter int RAM_DEPTH       = 256,
    parameter int RAM_WAIT_STATES = 2
)
(
    input  logic             clk_i,
    input  logic             rstn_i,

    // master port
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  wb_pkg::wb_addr_t addr,
    input  wb_pkg::wb_sel_t  sel,
    input  wb_pkg::wb_data_t wdata,
    output wb_pkg::wb_data_t rdata,
    output logic             ack,
    output logic             err,
    output logic             stall,

    // gpio pins
    input  wb_pkg::gpio_t    gpio_in,
    output wb_pkg::gpio_t    gpio_out
);

    import wb_pkg::*;

    localparam int       NUM_SLAVES = 2;
    localparam wb_addr_t SLAVE_BASE [NUM_SLAVES] = '{RAM_BASE, GPIO_BASE};
    localparam wb_addr_t SLAVE_MASK [NUM_SLAVES] = '{RAM_MASK, GPIO_MASK};

    logic [NUM_SLAVES-1:0]     s_cyc;
    logic [NUM_SLAVES-1:0]     s_stb;
    logic [NUM_SLAVES-1:0]     s_ack;
    logic [NUM_SLAVES-1:0]     s_stall;
    wb_data_t [NUM_SLAVES-1:0] s_rdata;
    logic                      s_we;
    wb_addr_t                  s_addr;
    wb_sel_t                   s_sel;
    wb_data_t                  s_wdata;

    wb_interconnect
    #(
        .NUM_SLAVES    (NUM_SLAVES),
        .START_ADDRESS (SLAVE_BASE),
        .MASK          (SLAVE_MASK)
    )
    wb_interconnect_inst
    (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .addr    (addr),
        .sel     (sel),
        .wdata   (wdata),
        .rdata   (rdata),
        .ack     (ack),
        .err     (err),
        .stall   (stall),
        .s_cyc   (s_cyc),
        .s_stb   (s_stb),
        .s_we    (s_we),
        .s_addr  (s_addr),
        .s_sel   (s_sel),
        .s_wdata (s_wdata),
        .s_ack   (s_ack),
        .s_stall (s_stall),
        .s_rdata (s_rdata)
    );

    wb_ram_slave
    #(
        .RAM_DEPTH       (RAM_DEPTH),
        .RAM_WAIT_STATES (RAM_WAIT_STATES)
    )
    wb_ram_slave_inst
    (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .cyc    (s_cyc[0]),
        .stb    (s_stb[0]),
        .we     (s_we),
        .addr   (s_addr),
        .sel    (s_sel),
        .wdata  (s_wdata),
        .rdata  (s_rdata[0]),
        .ack    (s_ack[0]),
        .stall  (s_stall[0])
    );

    wb_gpio_slave wb_gpio_slave_inst
    (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cyc      (s_cyc[1]),
        .stb      (s_stb[1]),
        .we       (s_we),
        .addr     (s_addr),
        .sel      (s_sel),
        .wdata    (s_wdata),
        .gpio_in  (gpio_in),
        .rdata    (s_rdata[1]),
        .ack      (s_ack[1]),
        .stall    (s_stall[1]),
        .gpio_out (gpio_out)
    );

endmodule : wb_subsystem

`default_nettype wire

// File: tests/wb_subsystem_tb.sv
// self-checking testbench for the wishbone subsystem
// runs the bus operations of the test file against a ram mirror and a gpio model

`default_nettype none

module wb_subsystem_tb;

    import wb_pkg::*;

    // a smaller ram than the 1 KiB window, so word addresses alias
    localparam int          RAM_DEPTH       = 64;
    localparam int          RAM_WAIT_STATES = 2;
    localparam int          IDX_W           = $clog2(RAM_DEPTH);
    localparam int          SAMPLE_DELAY    = 1;
    localparam int          STALL_LIMIT     = 20;
    localparam int          ACK_LIMIT       = 20;
    localparam int          ERR_WATCH       = 3;
    localparam logic [15:0] LFSR_SEED       = 16'd27;
    localparam logic [15:0] LFSR_TAPS       = 16'hB400;
    localparam string       TEST_FILE       = "tests/wb_subsystem_tests.txt";

    typedef logic [IDX_W-1:0] idx_t;

    logic     clk_i;
    logic     rstn_i;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t addr;
    wb_sel_t  sel;
    wb_data_t wdata;
    wb_data_t rdata;
    logic     ack;
    logic     err;
    logic     stall;
    gpio_t    gpio_in;
    gpio_t    gpio_out;

    wb_data_t    ram_mirror [RAM_DEPTH];
    gpio_t       gpio_out_model;
    gpio_t       gpio_in_model;
    logic [15:0] lfsr_state;
    logic        aborted;

    int data_errors;
    int gpio_errors;
    int resp_errors;
    int timing_errors;
    int timeout_errors;
    int other_errors;

    wb_subsystem
    #(
        .RAM_DEPTH       (RAM_DEPTH),
        .RAM_WAIT_STATES (RAM_WAIT_STATES)
    )
    wb_subsystem_inst
    (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .addr     (addr),
        .sel      (sel),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .err      (err),
        .stall    (stall),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? LFSR_TAPS : 16'h0000);
    endfunction

    // one lfsr step per bit of the word
    task automatic random_word(output wb_data_t w);
        w = '0;
        for (int i = 0; i < $bits(wb_data_t); i++)
        begin
            w          = {w[$bits(wb_data_t)-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic idx_t ram_index(input wb_addr_t a);
        return idx_t'((a >> 2) % RAM_DEPTH);
    endfunction

    function automatic logic in_ram(input wb_addr_t a);
        return (a & RAM_MASK) == RAM_BASE;
    endfunction

    function automatic logic in_gpio(input wb_addr_t a);
        return (a & GPIO_MASK) == GPIO_BASE;
    endfunction

    function automatic wb_data_t model_read(input wb_addr_t a);
        wb_addr_t ofs;
        ofs = a & ~GPIO_MASK;
        if (in_ram(a))
            return ram_mirror[ram_index(a)];
        if (in_gpio(a) && ofs == wb_addr_t'(GPIO_OUT_OFS))
            return wb_data_t'(gpio_out_model);
        if (in_gpio(a) && ofs == wb_addr_t'(GPIO_IN_OFS))
            return wb_data_t'(gpio_in_model);
        return '0;
    endfunction

    task automatic model_write(input wb_addr_t a, input wb_sel_t s, input wb_data_t d);
        wb_addr_t ofs;
        ofs = a & ~GPIO_MASK;
        if (in_ram(a))
        begin
            for (int b = 0; b < $bits(wb_sel_t); b++)
            begin
                if (s[b])
                    ram_mirror[ram_index(a)][8*b +: 8] = d[8*b +: 8];
            end
        end
        else if (in_gpio(a) && ofs == wb_addr_t'(GPIO_OUT_OFS) && s[0])
        begin
            gpio_out_model = d[$bits(gpio_t)-1:0];
        end
    endtask

    task automatic check_data(input string name, input wb_data_t expected, input wb_data_t actual);
        if (actual !== expected)
        begin
            data_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t expected, input gpio_t actual);
        if (actual !== expected)
        begin
            gpio_errors++;
            $display("FAILED %s: expected gpio_out %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input logic exp_ack, input logic exp_err,
                              input logic got_ack, input logic got_err);
        if (got_ack !== exp_ack || got_err !== exp_err)
        begin
            resp_errors++;
            $display("FAILED %s: expected ack=%b err=%b, actual ack=%b err=%b",
                     name, exp_ack, exp_err, got_ack, got_err);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            timing_errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        aborted = 1'b1;
        $display("ERROR: timed out waiting for %s", what);
    endtask

    // one request, held while stalled, then waits for ack or err
    task automatic bus_access(input logic write, input wb_addr_t a, input wb_sel_t s,
                              input wb_data_t d, output wb_data_t rd, output logic got_ack,
                              output logic got_err, output int stalls, output int latency);
        int   cycles;
        logic accepted;
        rd       = '0;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        stalls   = 0;
        latency  = 0;
        cycles   = 0;
        accepted = 1'b0;
        @(negedge clk_i);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        addr  = a;
        sel   = s;
        wdata = d;
        while (!accepted && !aborted)
        begin
            #SAMPLE_DELAY;
            got_err  = err;
            accepted = err | ~stall;
            if (!accepted)
                stalls++;
            @(negedge clk_i);
            cycles++;
            if (!accepted && cycles >= STALL_LIMIT)
                report_timeout("stall to drop");
        end
        stb = 1'b0;
        if (got_err)
        begin
            cyc = 1'b0;
            // an unmapped request must never be acked afterwards
            for (int i = 0; i < ERR_WATCH; i++)
            begin
                #SAMPLE_DELAY;
                if (ack)
                    got_ack = 1'b1;
                @(negedge clk_i);
            end
        end
        else if (!aborted)
        begin
            while (!got_ack && !aborted)
            begin
                #SAMPLE_DELAY;
                if (ack)
                begin
                    got_ack = 1'b1;
                    rd      = rdata;
                    latency = cycles;
                end
                else
                begin
                    @(negedge clk_i);
                    cycles++;
                    if (cycles >= ACK_LIMIT)
                        report_timeout("ack");
                end
            end
            if (got_ack)
                @(negedge clk_i);
            cyc = 1'b0;
        end
        we = 1'b0;
    endtask

    task automatic single_access(input string name, input logic write, input wb_addr_t a,
                                 input wb_data_t d, input wb_sel_t s,
                                 input logic exp_ack, input logic exp_err);
        wb_data_t rd;
        wb_data_t expected;
        logic     got_ack;
        logic     got_err;
        int       stalls;
        int       latency;
        expected = model_read(a);
        bus_access(write, a, s, d, rd, got_ack, got_err, stalls, latency);
        if (aborted)
            return;
        check_resp(name, exp_ack, exp_err, got_ack, got_err);
        if (got_ack)
        begin
            // ram stalls once per wait state, gpio never stalls
            check_count({name, " stalls"}, in_ram(a) ? RAM_WAIT_STATES : 0, stalls);
            check_count({name, " latency"}, in_ram(a) ? RAM_WAIT_STATES + 2 : 2, latency);
        end
        if (write)
            model_write(a, s, d);
        else if (got_ack)
            check_data(name, expected, rd);
        if (in_gpio(a))
            check_gpio(name, gpio_out_model, gpio_out);
    endtask

    // writes count random words from a upwards, then reads them all back
    task automatic random_fill(input string name, input wb_addr_t a, input int count,
                               input wb_sel_t s, input logic exp_ack, input logic exp_err);
        wb_data_t w;
        for (int k = 0; k < count && !aborted; k++)
        begin
            random_word(w);
            single_access($sformatf("%s_w%0d", name, k), 1'b1, a + wb_addr_t'(4 * k),
                          w, s, exp_ack, exp_err);
        end
        for (int k = 0; k < count && !aborted; k++)
        begin
            single_access($sformatf("%s_r%0d", name, k), 1'b0, a + wb_addr_t'(4 * k),
                          '0, s, exp_ack, exp_err);
        end
    endtask

    task automatic run_test(input string name, input string op, input wb_addr_t a,
                            input wb_data_t d, input wb_sel_t s, input string outcome);
        if (op == "write" || op == "read")
        begin
            single_access(name, op == "write", a, d, s, outcome == "ack", outcome == "err");
        end
        else if (op == "setin")
        begin
            @(negedge clk_i);
            gpio_in       = d[$bits(gpio_t)-1:0];
            gpio_in_model = d[$bits(gpio_t)-1:0];
            // two synchroniser flops, plus some margin
            repeat (4) @(negedge clk_i);
        end
        else if (op == "fill")
        begin
            random_fill(name, a, int'(d), s, outcome == "ack", outcome == "err");
        end
        else
        begin
            other_errors++;
            $display("ERROR: unknown opcode %s in test %s", op, name);
        end
    endtask

    initial
    begin
        int       fd;
        int       fields;
        int       total;
        string    line;
        string    name;
        string    op;
        string    outcome;
        wb_addr_t a;
        wb_data_t d;
        wb_sel_t  s;

        clk_i          = 1'b0;
        rstn_i         = 1'b0;
        cyc            = 1'b0;
        stb            = 1'b0;
        we             = 1'b0;
        addr           = '0;
        sel            = '0;
        wdata          = '0;
        gpio_in        = '0;
        ram_mirror     = '{default: '0};
        gpio_out_model = '0;
        gpio_in_model  = '0;
        lfsr_state     = LFSR_SEED;
        aborted        = 1'b0;
        data_errors    = 0;
        gpio_errors    = 0;
        resp_errors    = 0;
        timing_errors  = 0;
        timeout_errors = 0;
        other_errors   = 0;

        repeat (16) @(negedge clk_i);
        check_resp("reset", 1'b0, 1'b0, ack, err);
        check_count("reset stall", 0, int'(stall));
        check_data("reset rdata", '0, rdata);
        check_gpio("reset gpio_out", '0, gpio_out);
        rstn_i = 1'b1;

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("ERROR: cannot open test file %s", TEST_FILE);
        end
        else
        begin
            while (!aborted && $fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    fields = $sscanf(line, "%s %s %h %h %h %s", name, op, a, d, s, outcome);
                    if (fields == 6)
                    begin
                        run_test(name, op, a, d, s, outcome);
                    end
                    else
                    begin
                        other_errors++;
                        $display("ERROR: malformed test line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end

        total = data_errors + gpio_errors + resp_errors + timing_errors
              + timeout_errors + other_errors;
        $display("errors: data %0d, gpio %0d, response %0d, timing %0d, timeout %0d, other %0d",
                 data_errors, gpio_errors, resp_errors, timing_errors, timeout_errors,
                 other_errors);
        if (total == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule : wb_subsystem_tb

`default_nettype wire

// File: tests/wb_subsystem_tests.txt
# columns: name opcode address data select outcome, all numbers in hex
# opcodes write, read, setin, fill (fill takes a word count as data)
ram_full_w0     write  00000000  11223344  f  ack
ram_full_r0     read   00000000  00000000  f  ack
ram_full_w1     write  00000004  a5a5a5a5  f  ack
ram_byte0_w1    write  00000004  000000ee  1  ack
ram_byte0_r1    read   00000004  00000000  f  ack
ram_byte3_w1    write  00000004  77000000  8  ack
ram_byte3_r1    read   00000004  00000000  f  ack
ram_upper_w1    write  00000004  12340000  c  ack
ram_upper_r1    read   00000004  00000000  f  ack
ram_mixed_w0    write  00000000  deadbeef  5  ack
ram_none_w0     write  00000000  ffffffff  0  ack
ram_mixed_r0    read   00000000  00000000  f  ack
ram_last_w      write  000000fc  cafef00d  f  ack
ram_alias_r     read   000001fc  00000000  f  ack
ram_alias_w     write  00000104  0badc0de  f  ack
ram_alias_r1    read   00000004  00000000  f  ack
gpio_out_w      write  00010000  000000a5  f  ack
gpio_out_r      read   00010000  00000000  f  ack
gpio_out_nosel  write  00010000  0000005a  e  ack
gpio_out_r2     read   00010000  00000000  f  ack
gpio_out_w2     write  00010000  ffffff3c  1  ack
gpio_out_r3     read   00010000  00000000  f  ack
gpio_in_set     setin  00000000  000000c3  0  -
gpio_in_r       read   00010004  00000000  f  ack
gpio_in_w       write  00010004  00000011  f  ack
gpio_in_r2      read   00010004  00000000  f  ack
gpio_out_r4     read   00010000  00000000  f  ack
gpio_in_set2    setin  00000000  0000005e  0  -
gpio_in_r3      read   00010004  00000000  f  ack
gpio_hole_r     read   00010008  00000000  f  ack
unmapped_w      write  00000400  ffffffff  f  err
unmapped_r      read   00020000  00000000  f  err
unmapped_w2     write  00010010  000000ff  f  err
unmapped_hi     write  80000000  ffffffff  f  err
post_err_r0     read   00000000  00000000  f  ack
post_err_r1     read   00000004  00000000  f  ack
post_err_gpio   read   00010000  00000000  f  ack
fill_low        fill   00000000  00000060  f  ack
fill_mid        fill   00000240  00000040  f  ack
final_alias_r   read   00000100  00000000  f  ack
